//--- pwm_macros.svh
`ifndef PWM_MACROS_SVH
`define PWM_MACROS_SVH

// bus placement
`define PWM_BASE_ADDR 16'hFF10
`define PWM_ADDR_W 16

// channel count drives the address map
`define PWM_CHANNELS 4
`define PWM_CHAN_W 2

// ctrl, prescale, then period/duty pairs
`define PWM_REG_COUNT (2 + 2 * `PWM_CHANNELS)
`define PWM_RSEL_W 4

// register offsets from the base address
`define PWM_OFF_CTRL 4'd0
`define PWM_OFF_PRESCALE 4'd1
`define PWM_OFF_CHAN 4'd2 // period of channel n at 2+2n, duty at 3+2n

`endif

//--- pwm_pkg.sv
`include "pwm_macros.svh"

package pwm_pkg;

    // one bus access, qualified by req
    typedef struct packed {
        logic [`PWM_ADDR_W-1:0] addr;
        logic [7:0]             wdata;
        logic                   write; // 1 = write, 0 = read
    } bus_req_t;

    // period and duty of one channel
    typedef struct packed {
        logic [7:0] period;
        logic [7:0] duty;
    } pwm_cfg_t;

    // register kinds seen by the register file
    typedef enum logic [1:0] {
        REG_CTRL     = 2'd0,
        REG_PRESCALE = 2'd1,
        REG_PERIOD   = 2'd2,
        REG_DUTY     = 2'd3
    } reg_sel_e;

    // channel FSM
    typedef enum logic {
        CH_STOPPED = 1'b0,
        CH_RUNNING = 1'b1
    } chan_state_e;

endpackage

//--- pwm_bus_ctrl.sv
`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_bus_ctrl (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    req,
    input  pwm_pkg::bus_req_t       bus,
    output logic                    reg_we,
    output pwm_pkg::reg_sel_e       reg_kind,
    output logic [`PWM_CHAN_W-1:0]  reg_chan,
    output logic [7:0]              reg_wdata,
    output logic [`PWM_RSEL_W-1:0]  reg_rsel,
    input  logic [7:0]              reg_rdata,
    output logic [7:0]              rdata,
    output logic                    rdata_valid
);
    import pwm_pkg::*;

    logic [`PWM_ADDR_W-1:0] offset;
    logic                   in_range;
    logic [`PWM_RSEL_W-1:0] chan_off;

    // address relative to register 0
    assign offset = bus.addr - `PWM_BASE_ADDR;

    assign in_range = (bus.addr >= `PWM_BASE_ADDR) && (offset < `PWM_REG_COUNT);

    assign reg_rsel  = offset[`PWM_RSEL_W-1:0];
    assign reg_wdata = bus.wdata;

    // period/duty pairs start after ctrl and prescale
    assign chan_off = reg_rsel - `PWM_OFF_CHAN;
    assign reg_chan = chan_off[`PWM_CHAN_W:1];

    always_comb
    begin
        if (reg_rsel == `PWM_OFF_CTRL)
        begin
            reg_kind = REG_CTRL;
        end
        else if (reg_rsel == `PWM_OFF_PRESCALE)
        begin
            reg_kind = REG_PRESCALE;
        end
        else if (chan_off[0] == 1'b0)
        begin
            reg_kind = REG_PERIOD; // even offset within the pair
        end
        else
        begin
            reg_kind = REG_DUTY;
        end
    end

    // one-cycle write strobe, out-of-range writes are dropped
    assign reg_we = req && bus.write && in_range;

    // read data one cycle after the strobe
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            rdata_valid <= 1'b0;
            rdata       <= 8'd0;
        end
        else
        begin
            rdata_valid <= req && !bus.write;
            if (req && !bus.write)
            begin
                rdata <= in_range ? reg_rdata : 8'd0; // unmapped reads as 0
            end
        end
    end

endmodule

//--- pwm_cfg_regs.sv
`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_cfg_regs (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 reg_we,
    input  pwm_pkg::reg_sel_e                    reg_kind,
    input  logic [`PWM_CHAN_W-1:0]               reg_chan,
    input  logic [7:0]                           reg_wdata,
    input  logic [`PWM_RSEL_W-1:0]               reg_rsel,
    output logic [7:0]                           reg_rdata,
    output logic [`PWM_CHANNELS-1:0]             enable,
    output logic [7:0]                           prescale,
    output logic                                 prescale_wr,
    output pwm_pkg::pwm_cfg_t [`PWM_CHANNELS-1:0] shadow_cfg
);
    import pwm_pkg::*;

    logic [`PWM_RSEL_W-1:0] rd_off;
    logic [`PWM_CHAN_W-1:0] rd_chan;

    // lets the prescaler restart its count
    assign prescale_wr = reg_we && (reg_kind == REG_PRESCALE);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            enable     <= '0;
            prescale   <= 8'd0;
            shadow_cfg <= '0;
        end
        else if (reg_we)
        begin
            case (reg_kind)
                REG_CTRL:     enable <= reg_wdata[`PWM_CHANNELS-1:0];
                REG_PRESCALE: prescale <= reg_wdata;
                REG_PERIOD:   shadow_cfg[reg_chan].period <= reg_wdata;
                REG_DUTY:     shadow_cfg[reg_chan].duty <= reg_wdata;
                default:      ;
            endcase
        end
    end

    // readback index into the period/duty pairs
    assign rd_off  = reg_rsel - `PWM_OFF_CHAN;
    assign rd_chan = rd_off[`PWM_CHAN_W:1];

    always_comb
    begin
        if (reg_rsel == `PWM_OFF_CTRL)
        begin
            reg_rdata = {{(8 - `PWM_CHANNELS){1'b0}}, enable};
        end
        else if (reg_rsel == `PWM_OFF_PRESCALE)
        begin
            reg_rdata = prescale;
        end
        else if (rd_off[0] == 1'b0)
        begin
            reg_rdata = shadow_cfg[rd_chan].period;
        end
        else
        begin
            reg_rdata = shadow_cfg[rd_chan].duty;
        end
    end

endmodule

//--- pwm_prescaler.sv
`timescale 1ns/1ps

module pwm_prescaler (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] prescale,
    input  logic       prescale_wr,
    output logic       tick
);

    logic [7:0] count;

    // one tick every prescale+1 cycles
    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            count <= 8'd0;
            tick  <= 1'b0;
        end
        else if (prescale_wr)
        begin
            // new rate takes over from a known phase
            count <= 8'd0;
            tick  <= 1'b0;
        end
        else if (count >= prescale)
        begin
            count <= 8'd0;
            tick  <= 1'b1;
        end
        else
        begin
            count <= count + 8'd1;
            tick  <= 1'b0;
        end
    end

endmodule

//--- pwm_channel.sv
`timescale 1ns/1ps

module pwm_channel (
    input  logic              clk,
    input  logic              reset,
    input  logic              enable,
    input  logic              tick,
    input  pwm_pkg::pwm_cfg_t shadow_cfg,
    output logic              out
);
    import pwm_pkg::*;

    chan_state_e state;
    chan_state_e state_nxt;
    logic [7:0]  count;
    logic [7:0]  count_nxt;
    pwm_cfg_t    active;
    pwm_cfg_t    active_nxt;
    logic        out_nxt;

    always_comb
    begin
        state_nxt  = state;
        count_nxt  = count;
        active_nxt = active;
        if (!enable)
        begin
            state_nxt = CH_STOPPED;
            count_nxt = 8'd0;
        end
        else if (tick)
        begin
            case (state)
                CH_STOPPED:
                begin
                    // start of the first period
                    state_nxt  = CH_RUNNING;
                    count_nxt  = 8'd0;
                    active_nxt = shadow_cfg;
                end
                CH_RUNNING:
                begin
                    if (count == active.period)
                    begin
                        count_nxt  = 8'd0;
                        active_nxt = shadow_cfg; // new config at the period boundary
                    end
                    else
                    begin
                        count_nxt = count + 8'd1;
                    end
                end
                default:
                begin
                    state_nxt = CH_STOPPED;
                    count_nxt = 8'd0;
                end
            endcase
        end
    end

    // duty 0 never matches and duty > period always does
    assign out_nxt = (state_nxt == CH_RUNNING) && (count_nxt < active_nxt.duty);

    always_ff @(posedge clk)
    begin
        if (!reset)
        begin
            state  <= CH_STOPPED;
            count  <= 8'd0;
            active <= '0;
            out    <= 1'b0;
        end
        else
        begin
            state  <= state_nxt;
            count  <= count_nxt;
            active <= active_nxt;
            out    <= out_nxt;
        end
    end

endmodule

//--- pwm_periph.sv
`timescale 1ns/1ps
`include "pwm_macros.svh"

module pwm_periph (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     req,
    input  pwm_pkg::bus_req_t        bus,
    output logic [7:0]               rdata,
    output logic                     rdata_valid,
    output logic [`PWM_CHANNELS-1:0] pwm_out
);
    import pwm_pkg::*;

    logic                              reg_we;
    reg_sel_e                          reg_kind;
    logic [`PWM_CHAN_W-1:0]            reg_chan;
    logic [7:0]                        reg_wdata;
    logic [`PWM_RSEL_W-1:0]            reg_rsel;
    logic [7:0]                        reg_rdata;
    logic [`PWM_CHANNELS-1:0]          enable;
    logic [7:0]                        prescale;
    logic                              prescale_wr;
    pwm_cfg_t [`PWM_CHANNELS-1:0]      shadow_cfg;
    logic                              tick;

    pwm_bus_ctrl i_bus_ctrl (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .bus         (bus),
        .reg_we      (reg_we),
        .reg_kind    (reg_kind),
        .reg_chan    (reg_chan),
        .reg_wdata   (reg_wdata),
        .reg_rsel    (reg_rsel),
        .reg_rdata   (reg_rdata),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    pwm_cfg_regs i_cfg_regs (
        .clk         (clk),
        .reset       (reset),
        .reg_we      (reg_we),
        .reg_kind    (reg_kind),
        .reg_chan    (reg_chan),
        .reg_wdata   (reg_wdata),
        .reg_rsel    (reg_rsel),
        .reg_rdata   (reg_rdata),
        .enable      (enable),
        .prescale    (prescale),
        .prescale_wr (prescale_wr),
        .shadow_cfg  (shadow_cfg)
    );

    pwm_prescaler i_prescaler (
        .clk         (clk),
        .reset       (reset),
        .prescale    (prescale),
        .prescale_wr (prescale_wr),
        .tick        (tick)
    );

    // one channel per enable bit, shared tick
    for (genvar i = 0; i < `PWM_CHANNELS; i++)
    begin : g_chan
        pwm_channel i_channel (
            .clk        (clk),
            .reset      (reset),
            .enable     (enable[i]),
            .tick       (tick),
            .shadow_cfg (shadow_cfg[i]),
            .out        (pwm_out[i])
        );
    end

endmodule

//--- tb_pwm_periph.sv
`timescale 1ns/1ps
`include "pwm_macros.svh"

module tb_pwm_periph;
    import pwm_pkg::*;

    localparam int N     = `PWM_CHANNELS;
    localparam int NREGS = `PWM_REG_COUNT;

    // phase lengths in cycles
    localparam int LEN_RESET    = 8;
    localparam int LEN_READBACK = 120;
    localparam int LEN_RANGE    = 120;
    localparam int LEN_DUTY     = 3 * 620;
    localparam int LEN_LIMIT    = 420;
    localparam int LEN_UPDATE   = 820;
    localparam int LEN_ENABLE   = 820;
    localparam int LEN_END      = 8;
    localparam int LEN_TOTAL    = LEN_RESET + LEN_READBACK + LEN_RANGE + LEN_DUTY
                                  + LEN_LIMIT + LEN_UPDATE + LEN_ENABLE + LEN_END;
    localparam int CYCLE_LIMIT  = LEN_TOTAL + LEN_TOTAL / 10;

    logic         clk;
    logic         reset;
    logic         req;
    bus_req_t     bus;
    logic [7:0]   rdata;
    logic         rdata_valid;
    logic [N-1:0] pwm_out;

    // reference model state
    logic [N-1:0] m_enable;
    logic [7:0]   m_prescale;
    logic [7:0]   m_period [N];
    logic [7:0]   m_duty [N];
    logic [7:0]   m_pcount;
    logic         m_tick;
    logic         m_running [N];
    logic [7:0]   m_count [N];
    logic [7:0]   m_act_period [N];
    logic [7:0]   m_act_duty [N];
    logic [N-1:0] m_out;
    logic [7:0]   m_rdata;
    logic         m_rdata_valid;

    int          cycles;
    int          err_count;
    int unsigned seed_val;

    pwm_periph i_pwm_periph (
        .clk         (clk),
        .reset       (reset),
        .req         (req),
        .bus         (bus),
        .rdata       (rdata),
        .rdata_valid (rdata_valid),
        .pwm_out     (pwm_out)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #10 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            err_count = err_count + 1;
            $display("ERR %0t %s expected %0h got %0h", $time, name, expected, actual);
            $display("Test failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic addr_in_range(input logic [15:0] addr);
        int off;
        off = int'(addr) - int'(`PWM_BASE_ADDR);
        return (off >= 0) && (off < NREGS);
    endfunction

    // register contents as the model sees them
    function automatic logic [7:0] reg_value(input int off);
        int ch;
        ch = (off - 2) / 2;
        if (off == 0)
            return 8'(m_enable);
        else if (off == 1)
            return m_prescale;
        else if ((off - 2) % 2 == 0)
            return m_period[ch];
        else
            return m_duty[ch];
    endfunction

    always @(posedge clk)
    begin : model
        int   off;
        int   ch;
        logic hit;
        off = int'(bus.addr) - int'(`PWM_BASE_ADDR);
        hit = req && (off >= 0) && (off < NREGS);
        if (!reset)
        begin
            m_enable      = '0;
            m_prescale    = 8'd0;
            m_pcount      = 8'd0;
            m_tick        = 1'b0;
            m_out         = '0;
            m_rdata       = 8'd0;
            m_rdata_valid = 1'b0;
            for (int i = 0; i < N; i++)
            begin
                m_period[i]     = 8'd0;
                m_duty[i]       = 8'd0;
                m_running[i]    = 1'b0;
                m_count[i]      = 8'd0;
                m_act_period[i] = 8'd0;
                m_act_duty[i]   = 8'd0;
            end
        end
        else
        begin
            // read data sees the registers before this edge
            m_rdata_valid = req && !bus.write;
            if (req && !bus.write)
                m_rdata = hit ? reg_value(off) : 8'd0;

            for (int i = 0; i < N; i++)
            begin
                if (!m_enable[i])
                begin
                    m_running[i] = 1'b0;
                    m_count[i]   = 8'd0;
                end
                else if (m_tick)
                begin
                    if (!m_running[i] || m_count[i] == m_act_period[i])
                    begin
                        m_running[i]    = 1'b1; // start or period boundary
                        m_count[i]      = 8'd0;
                        m_act_period[i] = m_period[i];
                        m_act_duty[i]   = m_duty[i];
                    end
                    else
                        m_count[i] = m_count[i] + 8'd1;
                end
                m_out[i] = m_running[i] && (m_count[i] < m_act_duty[i]);
            end

            if (hit && bus.write && off == 1)
            begin
                m_pcount = 8'd0;
                m_tick   = 1'b0;
            end
            else if (m_pcount == m_prescale)
            begin
                m_pcount = 8'd0;
                m_tick   = 1'b1;
            end
            else
            begin
                m_pcount = m_pcount + 8'd1;
                m_tick   = 1'b0;
            end

            if (hit && bus.write)
            begin
                ch = (off - 2) / 2;
                if (off == 0)
                    m_enable = bus.wdata[N-1:0];
                else if (off == 1)
                    m_prescale = bus.wdata;
                else if ((off - 2) % 2 == 0)
                    m_period[ch] = bus.wdata;
                else
                    m_duty[ch] = bus.wdata;
            end
        end
    end

    // outputs are settled by the falling edge
    always @(negedge clk)
    begin
        if (cycles > 0)
        begin
            check_value("rdata_valid", 32'(m_rdata_valid), 32'(rdata_valid));
            check_value("rdata", 32'(m_rdata), 32'(rdata));
            for (int i = 0; i < N; i++)
                check_value($sformatf("pwm_out[%0d]", i), 32'(m_out[i]), 32'(pwm_out[i]));
        end
    end

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > CYCLE_LIMIT)
        begin
            $display("timeout: the run went past %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $fatal(1, "timeout");
        end
    end

    // one call is one bus cycle
    task automatic drive_bus(input logic r, input logic [15:0] addr, input logic [7:0] data,
                             input logic write);
        @(posedge clk);
        #2;
        req       = r;
        bus.addr  = addr;
        bus.wdata = data;
        bus.write = write;
    endtask

    task automatic write_reg(input int off, input logic [7:0] data);
        drive_bus(1'b1, `PWM_BASE_ADDR + 16'(off), data, 1'b1);
    endtask

    task automatic read_reg(input int off);
        drive_bus(1'b1, `PWM_BASE_ADDR + 16'(off), 8'($urandom), 1'b0);
    endtask

    task automatic read_all_regs();
        for (int off = 0; off < NREGS; off++)
            read_reg(off);
    endtask

    task automatic idle(input int n);
        repeat (n)
            drive_bus(1'b0, 16'($urandom), 8'($urandom), 1'($urandom)); // bus noise, no req
    endtask

    initial
    begin : stimulus
        logic [15:0] addr;
        int          p;
        int          pick;
        seed_val  = $urandom(32'h2f019981);
        cycles    = 0;
        err_count = 0;
        reset     = 1'b0;
        req       = 1'b0;
        bus       = '0;
        repeat (4) @(posedge clk);
        #2;
        reset = 1'b1;

        // register readback
        repeat (100)
        begin
            if ($urandom_range(1, 0) == 1)
                write_reg($urandom_range(NREGS - 1, 0), 8'($urandom));
            else
                read_reg($urandom_range(NREGS - 1, 0));
        end
        read_all_regs();
        idle(1);

        // unmapped addresses
        repeat (100)
        begin
            addr = 16'($urandom);
            if (addr_in_range(addr))
                addr = addr ^ 16'h8000;
            drive_bus(1'b1, addr, 8'($urandom), 1'($urandom));
        end
        read_all_regs();
        idle(1);

        // duty and period
        for (int round = 0; round < 3; round++)
        begin
            write_reg(1, 8'($urandom_range(3, 0)));
            for (int i = 0; i < N; i++)
            begin
                p = $urandom_range(15, 0);
                write_reg(2 + 2 * i, 8'(p));
                write_reg(3 + 2 * i, 8'($urandom_range(p, 0)));
            end
            write_reg(0, 8'((1 << N) - 1));
            idle(600);
        end

        // duty 0 on even channels, duty past the period on odd ones
        for (int i = 0; i < N; i++)
        begin
            p = $urandom_range(20, 0);
            write_reg(2 + 2 * i, 8'(p));
            write_reg(3 + 2 * i, (i % 2 == 0) ? 8'd0 : 8'($urandom_range(255, p + 1)));
        end
        write_reg(0, 8'((1 << N) - 1));
        idle(400);

        // rewrites while running
        write_reg(0, 8'((1 << N) - 1));
        repeat (800)
        begin
            pick = $urandom_range(N - 1, 0);
            if ($urandom_range(15, 0) != 0)
                idle(1);
            else if ($urandom_range(1, 0) == 1)
                write_reg(2 + 2 * pick, 8'($urandom_range(15, 0)));
            else
                write_reg(3 + 2 * pick, 8'($urandom_range(17, 0)));
        end

        // enable toggling
        repeat (800)
        begin
            pick = $urandom_range(19, 0);
            if (pick == 0)
                write_reg(0, 8'($urandom_range((1 << N) - 1, 0)));
            else if (pick == 1)
                read_reg($urandom_range(NREGS - 1, 0));
            else if (pick == 2)
                write_reg(1, 8'($urandom_range(3, 0)));
            else
                idle(1);
        end
        idle(4);

        if (err_count == 0)
        begin
            $display("Test passed");
            $finish;
        end
        else
        begin
            $display("Test failed");
            $fatal(1, "checks failed");
        end
    end

endmodule

//--- compile.f
+incdir+.
pwm_pkg.sv
pwm_bus_ctrl.sv
pwm_cfg_regs.sv
pwm_prescaler.sv
pwm_channel.sv
pwm_periph.sv
tb_pwm_periph.sv

//--- Makefile
TOP = tb_pwm_periph

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the simulation"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	verilator --binary --timing -Wno-fatal -f compile.f --top-module $(TOP) -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Test passed$$"

clean:
	rm -rf obj_dir
